/* design/disc_defines.svh */
/*
  sample discriminator build constants
  channel layout, sample format, delay range and counter widths
*/
`ifndef DISC_DEFINES_SVH
`define DISC_DEFINES_SVH

// capture channels and parallel samples per input word
`define DISC_CHANNELS 2
`define DISC_LANES 2
`define DISC_SAMPLE_WIDTH 16

// largest start or stop delay plus one
`define DISC_MAX_DELAY 16
// width of a start or stop delay field
`define DISC_DELAY_WIDTH 4
// cycles from an input word to the state decision it causes
`define DISC_LATENCY 2

// timestamp fields
`define DISC_TIME_WIDTH 32
`define DISC_INDEX_WIDTH 16

`endif

/* design/disc_pkg.sv */
/*
  shared types of the sample discriminator
  samples, lane words, channel configuration, stream and timestamp records
*/
`include "disc_defines.svh"

package disc_pkg;

  typedef logic signed [`DISC_SAMPLE_WIDTH-1:0] sample_t;

  // one input word, moved as raw bits and compared as separate samples
  typedef union packed {
    logic [`DISC_LANES*`DISC_SAMPLE_WIDTH-1:0] raw;
    sample_t [`DISC_LANES-1:0] lane;
  } lane_word_u;

  // per-channel settings, 41 bits
  typedef struct packed {
    sample_t threshold_high;
    sample_t threshold_low;
    logic [`DISC_DELAY_WIDTH-1:0] start_delay;
    logic [`DISC_DELAY_WIDTH-1:0] stop_delay;
    logic bypass;
  } chan_cfg_t;

  typedef chan_cfg_t [`DISC_CHANNELS-1:0] cfg_t;

  // detector levels handed from the control block to the comparators
  typedef struct packed {
    sample_t high;
    sample_t low;
  } thresh_pair_t;

  // all channels of one cycle, 66 bits
  typedef struct packed {
    lane_word_u [`DISC_CHANNELS-1:0] data;
    logic [`DISC_CHANNELS-1:0] valid;
  } stream_t;

  // arrival time of the first kept sample and the number of samples saved before it
  typedef struct packed {
    logic [`DISC_TIME_WIDTH-1:0] ts_time;
    logic [`DISC_INDEX_WIDTH-1:0] ts_index;
  } timestamp_t;

endpackage

/* design/threshold_detect.sv */
/*
  threshold detector
  registered compare of every lane of a word against the channel's two levels
*/
`include "disc_defines.svh"

module threshold_detect (
  input  logic adc_clk,
  input  logic adc_reset,
  input  logic reset_state,
  input  disc_pkg::stream_t data_in,
  input  disc_pkg::thresh_pair_t [`DISC_CHANNELS-1:0] thresholds,
  output logic [`DISC_CHANNELS-1:0] any_above_high,
  output logic [`DISC_CHANNELS-1:0] all_below_low
);

  // raw compare results, not yet qualified
  logic [`DISC_CHANNELS-1:0] hit_high;
  logic [`DISC_CHANNELS-1:0] hit_low;
  // word takes part in detection only when valid and outside reset_state
  logic [`DISC_CHANNELS-1:0] word_ok;

  always_comb begin
    hit_high = '0;
    hit_low = '0;
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      for (int ln = 0; ln < `DISC_LANES; ln++) begin
        // signed compare, lanes viewed as samples
        if (disc_pkg::sample_t'(data_in.data[ch].lane[ln]) > thresholds[ch].high) begin
          hit_high[ch] = 1'b1;
        end
        if (disc_pkg::sample_t'(data_in.data[ch].lane[ln]) > thresholds[ch].low) begin
          hit_low[ch] = 1'b1;
        end
      end
    end
    word_ok = data_in.valid & {`DISC_CHANNELS{~reset_state}};
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      any_above_high <= '0;
      all_below_low <= '0;
    end else begin
      // start event when any lane is strictly above high
      any_above_high <= word_ok & hit_high;
      // quiet word when no lane is above low
      all_below_low <= word_ok & ~hit_low;
    end
  end

endmodule

/* design/sample_delay_line.sv */
/*
  sample delay line
  holds words and valids long enough to keep the start_delay samples before an
  event, with a per-channel tap and valid gated by the channel's active flag
*/
`include "disc_defines.svh"

module sample_delay_line (
  input  logic adc_clk,
  input  disc_pkg::stream_t data_in,
  input  logic [`DISC_CHANNELS-1:0][`DISC_DELAY_WIDTH-1:0] start_delay,
  input  logic [`DISC_CHANNELS-1:0] active,
  output disc_pkg::stream_t samples_out
);

  // input word plus these registers gives DISC_MAX_DELAY + DISC_LATENCY taps
  localparam int DEPTH = `DISC_MAX_DELAY + `DISC_LATENCY - 1;
  localparam int TAP_W = $clog2(DEPTH);

  // pipe[k] holds the word that arrived k+1 cycles ago
  disc_pkg::stream_t pipe [DEPTH];
  logic [`DISC_CHANNELS-1:0][TAP_W-1:0] tap;

  //////////////////////////////////////////////////////////////////////
  // shift pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    pipe[0] <= data_in;
    for (int k = 1; k < DEPTH; k++) begin
      pipe[k] <= pipe[k-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tap select and output register
  //////////////////////////////////////////////////////////////////////

  // tap start_delay + latency, counted from the input word
  always_comb begin
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      tap[ch] = TAP_W'(start_delay[ch]) + TAP_W'(`DISC_LATENCY - 1);
    end
  end

  // words move as raw bits here, nothing looks inside them
  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      samples_out.data[ch].raw <= pipe[tap[ch]].data[ch].raw;
      samples_out.valid[ch] <= pipe[tap[ch]].valid[ch] & active[ch];
    end
  end

endmodule

/* design/capture_control.sv */
/*
  capture control
  config register and per-channel DISABLED/PRECAPTURE/CAPTURE machine
  with a retriggerable start counter and a stop counter
*/
`include "disc_defines.svh"

module capture_control (
  input  logic adc_clk,
  input  logic adc_reset,
  input  logic reset_state,
  input  logic cfg_load,
  input  disc_pkg::cfg_t cfg,
  input  logic [`DISC_CHANNELS-1:0] any_above_high,
  input  logic [`DISC_CHANNELS-1:0] all_below_low,
  output disc_pkg::thresh_pair_t [`DISC_CHANNELS-1:0] thresholds,
  output logic [`DISC_CHANNELS-1:0][`DISC_DELAY_WIDTH-1:0] start_delay,
  output logic [`DISC_CHANNELS-1:0] active
);

  // stop count spans start_delay + stop_delay
  localparam int STOP_W = `DISC_DELAY_WIDTH + 1;

  typedef enum logic [1:0] {DISABLED, PRECAPTURE, CAPTURE} state_e;

  disc_pkg::cfg_t cfg_q;
  state_e state [`DISC_CHANNELS];
  logic [`DISC_CHANNELS-1:0][`DISC_DELAY_WIDTH-1:0] start_cnt;
  logic [`DISC_CHANNELS-1:0][STOP_W-1:0] stop_cnt;
  // stop countdown running
  logic [`DISC_CHANNELS-1:0] stop_pend;

  // config taken whole on the load strobe
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      cfg_q <= '0;
    end else if (cfg_load) begin
      cfg_q <= cfg;
    end
  end

  always_comb begin
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      thresholds[ch].high = cfg_q[ch].threshold_high;
      thresholds[ch].low = cfg_q[ch].threshold_low;
      start_delay[ch] = cfg_q[ch].start_delay;
      // bypass keeps the channel open all the time
      active[ch] = (state[ch] != DISABLED) | cfg_q[ch].bypass;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // per-channel state machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (adc_reset | reset_state) begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        state[ch] <= DISABLED;
      end
      start_cnt <= '0;
      stop_cnt <= '0;
      stop_pend <= '0;
    end else begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        // stop path, armed by the first quiet word after the last start
        if (any_above_high[ch] || state[ch] == DISABLED) begin
          stop_pend[ch] <= 1'b0;
        end else if (!stop_pend[ch] && all_below_low[ch]) begin
          stop_pend[ch] <= 1'b1;
          stop_cnt[ch] <= STOP_W'(cfg_q[ch].start_delay) + STOP_W'(cfg_q[ch].stop_delay);
        end else if (stop_pend[ch] && stop_cnt[ch] != '0) begin
          stop_cnt[ch] <= stop_cnt[ch] - 1'b1;
        end

        // start path, a new event always reloads it
        if (any_above_high[ch]) begin
          if (cfg_q[ch].start_delay == '0) begin
            // nothing to keep before the event, open at once
            state[ch] <= CAPTURE;
          end else begin
            state[ch] <= PRECAPTURE;
            start_cnt[ch] <= cfg_q[ch].start_delay - 1'b1;
          end
        end else begin
          case (state[ch])
            PRECAPTURE: begin
              if (start_cnt[ch] == '0) begin
                state[ch] <= CAPTURE;
              end else begin
                start_cnt[ch] <= start_cnt[ch] - 1'b1;
              end
            end
            CAPTURE: begin
              if (stop_pend[ch] && stop_cnt[ch] == '0) begin
                state[ch] <= DISABLED;
              end
            end
            default: begin
            end
          endcase
        end
      end
    end
  end

endmodule

/* design/timestamp_gen.sv */
/*
  timestamp generator
  free time counter and saved-sample index per channel, one timestamp
  pulse each time a channel opens
*/
`include "disc_defines.svh"

module timestamp_gen (
  input  logic adc_clk,
  input  logic adc_reset,
  input  logic reset_state,
  input  logic [`DISC_CHANNELS-1:0] active,
  input  logic [`DISC_CHANNELS-1:0] out_valid,
  output disc_pkg::timestamp_t [`DISC_CHANNELS-1:0] ts_data,
  output logic [`DISC_CHANNELS-1:0] ts_valid
);

  logic [`DISC_TIME_WIDTH-1:0] time_cnt;
  logic [`DISC_CHANNELS-1:0][`DISC_INDEX_WIDTH-1:0] sample_index;
  logic [`DISC_CHANNELS-1:0] active_d;
  // output valid trails active by a cycle, so the clear is held one cycle longer
  logic reset_state_d;

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      time_cnt <= '0;
      sample_index <= '0;
      active_d <= '0;
      reset_state_d <= 1'b0;
      ts_valid <= '0;
    end else begin
      time_cnt <= time_cnt + 1'b1;
      reset_state_d <= reset_state;
      active_d <= active;
      // one pulse per rising edge of active
      ts_valid <= active & ~active_d;
      if (reset_state | reset_state_d) begin
        sample_index <= '0;
      end else begin
        for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
          if (out_valid[ch]) begin
            sample_index[ch] <= sample_index[ch] + 1'b1;
          end
        end
      end
    end
  end

  // record held until the next channel open
  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      if (active[ch] & ~active_d[ch]) begin
        ts_data[ch].ts_time <= time_cnt;
        ts_data[ch].ts_index <= sample_index[ch];
      end
    end
  end

endmodule

/* design/sample_discriminator.sv */
/*
  sample discriminator top
  passes only the samples around threshold events on each capture channel
  and emits a timestamp whenever a channel opens
*/
`include "disc_defines.svh"

module sample_discriminator (
  input  logic adc_clk,
  input  logic adc_reset,
  input  logic reset_state,
  input  logic cfg_load,
  input  disc_pkg::cfg_t cfg,
  input  disc_pkg::stream_t adc_data_in,
  output disc_pkg::stream_t adc_samples_out,
  output disc_pkg::timestamp_t [`DISC_CHANNELS-1:0] ts_data,
  output logic [`DISC_CHANNELS-1:0] ts_valid
);

  disc_pkg::thresh_pair_t [`DISC_CHANNELS-1:0] thresholds;
  logic [`DISC_CHANNELS-1:0][`DISC_DELAY_WIDTH-1:0] start_delay;
  logic [`DISC_CHANNELS-1:0] any_above_high;
  logic [`DISC_CHANNELS-1:0] all_below_low;
  // channel open or bypassed
  logic [`DISC_CHANNELS-1:0] active;

  // detection, one cycle after the input word
  threshold_detect u_detect (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .reset_state(reset_state),
    .data_in(adc_data_in),
    .thresholds(thresholds),
    .any_above_high(any_above_high),
    .all_below_low(all_below_low)
  );

  capture_control u_ctrl (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .reset_state(reset_state),
    .cfg_load(cfg_load),
    .cfg(cfg),
    .any_above_high(any_above_high),
    .all_below_low(all_below_low),
    .thresholds(thresholds),
    .start_delay(start_delay),
    .active(active)
  );

  // data path, start_delay + 3 cycles from input to output
  sample_delay_line u_delay (
    .adc_clk(adc_clk),
    .data_in(adc_data_in),
    .start_delay(start_delay),
    .active(active),
    .samples_out(adc_samples_out)
  );

  timestamp_gen u_ts (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .reset_state(reset_state),
    .active(active),
    .out_valid(adc_samples_out.valid),
    .ts_data(ts_data),
    .ts_valid(ts_valid)
  );

endmodule

/* tests/disc_chk.sv */
/*
  discriminator checker
  concurrent assertions on bypass, quiet channels, triggering words, stop and timestamps
*/
`include "disc_defines.svh"

module disc_chk (
  input logic adc_clk,
  input logic adc_reset,
  input logic reset_state,
  input logic cfg_load,
  input disc_pkg::cfg_t cfg,
  input disc_pkg::stream_t adc_data_in,
  input disc_pkg::stream_t adc_samples_out,
  input disc_pkg::timestamp_t [`DISC_CHANNELS-1:0] ts_data,
  input logic [`DISC_CHANNELS-1:0] ts_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  // input history deep enough for the largest start delay plus three
  localparam int HIST = `DISC_MAX_DELAY + 3;

  int unsigned err_cnt = 0;
  disc_pkg::cfg_t cfg_ref;
  // hist[k] is the word sampled k+1 edges ago
  disc_pkg::stream_t hist [HIST];
  logic [HIST-1:0] rs_hist;

  // any lane strictly above the level
  function automatic logic above(input disc_pkg::lane_word_u w, input disc_pkg::sample_t lvl);
    logic hit;
    hit = 1'b0;
    for (int ln = 0; ln < `DISC_LANES; ln++) begin
      if (w.lane[ln] > lvl) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      cfg_ref <= '0;
    end else if (cfg_load) begin
      cfg_ref <= cfg;
    end
    hist[0] <= adc_data_in;
    for (int k = 1; k < HIST; k++) begin
      hist[k] <= hist[k-1];
    end
    rs_hist <= {rs_hist[HIST-2:0], reset_state};
  end

  //////////////////////////////////////////////////////////////////////
  // per-channel reference state and assertions
  //////////////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < `DISC_CHANNELS; ch++) begin : g_ch
    int unsigned byp_age;
    int unsigned nbyp_age;
    int unsigned rs_age;
    int unsigned quiet_run;
    logic seen_high;
    logic first_ts;
    logic [`DISC_INDEX_WIDTH-1:0] cnt;
    logic [`DISC_INDEX_WIDTH-1:0] cnt_d;
    logic [`DISC_TIME_WIDTH-1:0] prev_time;
    logic [`DISC_TIME_WIDTH-1:0] ts_gap;
    logic have_prev;
    disc_pkg::stream_t ref_word;
    logic [`DISC_DELAY_WIDTH-1:0] sd;
    logic trig;
    logic rs_ok;
    logic in_high;
    logic in_quiet;

    always_comb begin
      sd = cfg_ref[ch].start_delay;
      // word that should be on the output now
      ref_word = hist[int'(sd) + 2];
      trig = ref_word.valid[ch] && above(ref_word.data[ch], cfg_ref[ch].threshold_high);
      // no reset_state over the whole path of that word
      rs_ok = (rs_hist & ((HIST'(1) << (sd + 3)) - HIST'(1))) == '0;
      in_high = adc_data_in.valid[ch] && !reset_state
        && above(adc_data_in.data[ch], cfg_ref[ch].threshold_high);
      in_quiet = adc_data_in.valid[ch] && !above(adc_data_in.data[ch], cfg_ref[ch].threshold_low);
    end

    always_ff @(posedge adc_clk) begin
      if (adc_reset) begin
        byp_age <= 0;
        nbyp_age <= 0;
        rs_age <= 0;
        quiet_run <= 0;
        seen_high <= 1'b0;
        first_ts <= 1'b0;
        cnt <= '0;
        cnt_d <= '0;
        prev_time <= '0;
        ts_gap <= '0;
        have_prev <= 1'b0;
      end else begin
        byp_age <= cfg_ref[ch].bypass ? byp_age + 1 : 0;
        nbyp_age <= cfg_ref[ch].bypass ? 0 : nbyp_age + 1;
        rs_age <= reset_state ? 0 : rs_age + 1;
        seen_high <= !reset_state && (seen_high || in_high);
        // invalid words neither extend nor break a quiet run
        if (adc_data_in.valid[ch] && !in_quiet) begin
          quiet_run <= 0;
        end else if (in_quiet) begin
          quiet_run <= quiet_run + 1;
        end
        first_ts <= reset_state || (first_ts && !ts_valid[ch]);
        // samples saved in reset_state and the cycle after do not count
        if (reset_state || rs_hist[0]) begin
          cnt <= '0;
        end else if (adc_samples_out.valid[ch]) begin
          cnt <= cnt + 1'b1;
        end
        cnt_d <= cnt;
        // cycles since the last timestamp on this channel
        ts_gap <= ts_valid[ch] ? `DISC_TIME_WIDTH'(1) : ts_gap + 1'b1;
        if (ts_valid[ch]) begin
          prev_time <= ts_data[ch].ts_time;
          have_prev <= 1'b1;
        end
      end
    end

    a_bypass: assert property (@(posedge adc_clk) disable iff (adc_reset)
      byp_age >= 20 |-> adc_samples_out.data[ch].raw == ref_word.data[ch].raw
        && adc_samples_out.valid[ch] == ref_word.valid[ch])
      else begin
        err_cnt++;
        $error("ERR %0t adc_samples_out[%0d] got %h/%b exp %h/%b", $time, ch,
          $sampled(adc_samples_out.data[ch].raw), $sampled(adc_samples_out.valid[ch]),
          $sampled(ref_word.data[ch].raw), $sampled(ref_word.valid[ch]));
      end

    a_quiet: assert property (@(posedge adc_clk) disable iff (adc_reset)
      !seen_high && rs_age >= 3 && nbyp_age >= 4 |-> !adc_samples_out.valid[ch])
      else begin
        err_cnt++;
        $error("ERR %0t adc_samples_out.valid[%0d] got 1 exp 0", $time, ch);
      end

    a_trigger: assert property (@(posedge adc_clk) disable iff (adc_reset)
      trig && rs_ok |-> adc_samples_out.valid[ch]
        && adc_samples_out.data[ch].raw == ref_word.data[ch].raw)
      else begin
        err_cnt++;
        $error("ERR %0t adc_samples_out[%0d] got %h/%b exp %h/1", $time, ch,
          $sampled(adc_samples_out.data[ch].raw), $sampled(adc_samples_out.valid[ch]),
          $sampled(ref_word.data[ch].raw));
      end

    a_stop: assert property (@(posedge adc_clk) disable iff (adc_reset)
      nbyp_age >= 4 && quiet_run >= int'(sd) + int'(cfg_ref[ch].stop_delay) + 8
        |-> !adc_samples_out.valid[ch])
      else begin
        err_cnt++;
        $error("ERR %0t adc_samples_out.valid[%0d] after stop got 1 exp 0", $time, ch);
      end

    a_ts_pulse: assert property (@(posedge adc_clk) disable iff (adc_reset)
      ts_valid[ch] |=> !ts_valid[ch])
      else begin
        err_cnt++;
        $error("ts_valid[%0d] stayed high for two cycles at %0t", ch, $time);
      end

    a_ts_index: assert property (@(posedge adc_clk) disable iff (adc_reset)
      ts_valid[ch] |-> ts_data[ch].ts_index == cnt_d)
      else begin
        err_cnt++;
        $error("ERR %0t ts_data[%0d].ts_index got %0d exp %0d", $time, ch,
          $sampled(ts_data[ch].ts_index), $sampled(cnt_d));
      end

    // free time advances one per cycle between two timestamps
    a_ts_time: assert property (@(posedge adc_clk) disable iff (adc_reset)
      ts_valid[ch] && have_prev |-> ts_data[ch].ts_time == prev_time + ts_gap)
      else begin
        err_cnt++;
        $error("ERR %0t ts_data[%0d].ts_time got %0d exp %0d", $time, ch,
          $sampled(ts_data[ch].ts_time), $sampled(prev_time + ts_gap));
      end

    // no saved sample before the first timestamp after reset_state
    a_ts_first: assert property (@(posedge adc_clk) disable iff (adc_reset)
      ts_valid[ch] && first_ts && rs_age >= 2 && !cfg_ref[ch].bypass
        |-> ts_data[ch].ts_index == '0)
      else begin
        err_cnt++;
        $error("ERR %0t ts_data[%0d].ts_index got %0d exp 0", $time, ch,
          $sampled(ts_data[ch].ts_index));
      end
  end

endmodule

bind sample_discriminator disc_chk u_chk (
  .adc_clk(adc_clk),
  .adc_reset(adc_reset),
  .reset_state(reset_state),
  .cfg_load(cfg_load),
  .cfg(cfg),
  .adc_data_in(adc_data_in),
  .adc_samples_out(adc_samples_out),
  .ts_data(ts_data),
  .ts_valid(ts_valid)
);

/* tests/tb_sample_discriminator.sv */
/*
  sample discriminator testbench
  LFSR stimulus through bypass, quiet, burst and reset_state phases
*/
`include "disc_defines.svh"

module tb_sample_discriminator;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int EVENTS = 14;
  // longest event is 4 loud plus 27 quiet cycles
  localparam int RUN_CYCLES = 8 + 4 + 64 + 4 + 65 + 2 * EVENTS * 32 + 30 + 100;

  logic adc_clk;
  logic adc_reset;
  logic reset_state;
  logic cfg_load;
  disc_pkg::cfg_t cfg;
  disc_pkg::stream_t adc_data_in;
  disc_pkg::stream_t adc_samples_out;
  disc_pkg::timestamp_t [`DISC_CHANNELS-1:0] ts_data;
  logic [`DISC_CHANNELS-1:0] ts_valid;
  logic [31:0] lfsr_state;

  sample_discriminator u_dut (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .reset_state(reset_state),
    .cfg_load(cfg_load),
    .cfg(cfg),
    .adc_data_in(adc_data_in),
    .adc_samples_out(adc_samples_out),
    .ts_data(ts_data),
    .ts_valid(ts_valid)
  );

  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
  endtask

  // loud words sit above threshold_high, the rest inside +-512
  task automatic drive_cycle(input logic loud, input logic rs);
    logic [15:0] r;
    @(posedge adc_clk);
    #10;
    reset_state = rs;
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      take_bits(4, r);
      adc_data_in.valid[ch] = (r != 0);
      for (int ln = 0; ln < `DISC_LANES; ln++) begin
        take_bits(10, r);
        if (loud) begin
          adc_data_in.data[ch].lane[ln] = disc_pkg::sample_t'(9000 + int'(r));
        end else begin
          adc_data_in.data[ch].lane[ln] = disc_pkg::sample_t'(int'(r) - 512);
        end
      end
    end
  endtask

  task automatic load_cfg(input logic bypass);
    @(posedge adc_clk);
    #10;
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      cfg[ch].threshold_high = 16'sd8000;
      cfg[ch].threshold_low = 16'sd2000;
      cfg[ch].start_delay = (ch == 0) ? 4'd3 : 4'd5;
      cfg[ch].stop_delay = (ch == 0) ? 4'd2 : 4'd1;
      cfg[ch].bypass = bypass;
    end
    cfg_load = 1'b1;
    @(posedge adc_clk);
    #10;
    cfg_load = 1'b0;
  endtask

  // short loud burst, then a quiet stretch long enough for the stop counter
  task automatic run_events(input int n, input logic with_rs);
    logic [15:0] burst;
    logic [15:0] quiet;
    logic [15:0] rs_at;
    for (int e = 0; e < n; e++) begin
      take_bits(2, burst);
      take_bits(3, quiet);
      take_bits(5, rs_at);
      for (int c = 0; c < int'(burst) + 1; c++) begin
        drive_cycle(1'b1, 1'b0);
      end
      for (int c = 0; c < int'(quiet) + 20; c++) begin
        drive_cycle(1'b0, with_rs && (c == int'(rs_at)));
      end
    end
  endtask

  initial begin
    logic [15:0] r;
    lfsr_state = 32'h745d;
    adc_reset = 1'b1;
    reset_state = 1'b0;
    cfg_load = 1'b0;
    cfg = '0;
    adc_data_in = '0;
    repeat (8) @(posedge adc_clk);
    #10;
    adc_reset = 1'b0;
    // bypass, mixed loud and quiet words
    load_cfg(1'b1);
    for (int i = 0; i < 64; i++) begin
      take_bits(3, r);
      drive_cycle(r == 0, 1'b0);
    end
    // bypass clear, noise below threshold_low only
    load_cfg(1'b0);
    drive_cycle(1'b0, 1'b1);
    repeat (64) drive_cycle(1'b0, 1'b0);
    run_events(EVENTS, 1'b0);
    run_events(EVENTS, 1'b1);
    repeat (30) drive_cycle(1'b0, 1'b0);
    if (u_dut.u_chk.err_cnt == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "checker reported assertion failures");
    end
  end

  // stop at the first assertion failure
  always @(posedge adc_clk) begin
    if (u_dut.u_chk.err_cnt != 0) begin
      $display("Simulation failed");
      $fatal(1, "assertion failure reported by disc_chk");
    end
  end

  initial begin
    #(RUN_CYCLES * 100);
    $display("Simulation failed");
    $fatal(1, "watchdog expired after %0d cycles", RUN_CYCLES);
  end

endmodule

/* sources.f */
+incdir+design
design/disc_pkg.sv
design/threshold_detect.sv
design/sample_delay_line.sv
design/capture_control.sv
design/timestamp_gen.sv
design/sample_discriminator.sv
tests/disc_chk.sv
tests/tb_sample_discriminator.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the sample discriminator testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_sample_discriminator \
  -f sources.f -o sim_tb

./obj_dir/sim_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
